//--- dinoPkg.sv
package dinoPkg;

  typedef logic [7:0] coordT; // screen coordinate, y grows upward
  typedef logic signed [7:0] velT; // pixels per frame
  typedef logic [15:0] scoreT; // obstacles cleared
  typedef logic [7:0] lfsrT; // obstacle generator state

  // dinosaur and physics
  localparam coordT floorY = 8'd151; // resting height
  localparam coordT jumpKick = 8'd10; // lift on the jump frame
  localparam velT jumpVel = 8'sd8; // launch velocity
  localparam velT gravity = 8'sd2; // velocity lost per frame
  localparam coordT dinoX = 8'd20; // left edge
  localparam coordT dinoW = 8'd10;

  // obstacles
  localparam coordT obsW = 8'd8;
  localparam coordT spawnX = 8'd160; // entry point on the right
  localparam coordT scrollStep = 8'd4; // pixels per frame
  localparam logic [2:0] gapFrames = 3'd6; // empty frames between obstacles
  localparam lfsrT lfsrSeed = 8'hA5;
  localparam lfsrT lfsrTaps = 8'hB8; // galois mask, taps 8 6 5 4
  localparam coordT minObsH = 8'd10; // base height, lfsr adds 0 to 15

endpackage

//--- obstacleIf.sv
`timescale 1ns/1ps

interface obstacleIf;

  logic active; // obstacle on screen
  dinoPkg::coordT x; // left edge
  dinoPkg::coordT height;
  logic passed; // one cycle, right edge went past the dinosaur

  modport scroller (
    output active, x, height, passed
  );

  modport judge (
    input active, x, height, passed
  );

endinterface

//--- frameTimer.sv
`timescale 1ns/1ps

module frameTimer #(
  parameter int unsigned frameDiv = 1000000
) (
  input logic clk,
  input logic nRst,
  input logic gameOver,
  output logic tick
);

  typedef logic [$clog2(frameDiv)-1:0] cntT;

  cntT cnt; // clocks left in the current frame

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      cnt <= cntT'(frameDiv - 1);
      tick <= 1'b0;
    end else if (gameOver) begin
      tick <= 1'b0; // counter frozen, no more frames
    end else if (cnt == '0) begin
      cnt <= cntT'(frameDiv - 1);
      tick <= 1'b1;
    end else begin
      cnt <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

//--- dinoJump.sv
`timescale 1ns/1ps

module dinoJump (
  input logic clk,
  input logic nRst,
  input logic tick,
  input logic button,
  output dinoPkg::coordT dinoY
);

  dinoPkg::velT vel;
  dinoPkg::velT nextVel;
  dinoPkg::coordT nextY;
  logic onFloor;
  logic signed [9:0] sumY; // height plus velocity, room for sign

  assign onFloor = (dinoY == dinoPkg::floorY);

  always_comb begin
    nextY = dinoY;
    nextVel = vel;
    sumY = $signed({2'b00, dinoY}) + vel;

    if (tick) begin
      if (onFloor) begin
        if (button) begin // takeoff only from the floor
          nextY = dinoPkg::floorY + dinoPkg::jumpKick;
          nextVel = dinoPkg::jumpVel;
        end
      end else if (sumY <= $signed({2'b00, dinoPkg::floorY})) begin
        nextY = dinoPkg::floorY; // touchdown
        nextVel = '0;
      end else begin
        nextY = sumY[7:0];
        nextVel = vel - dinoPkg::gravity;
      end
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      dinoY <= dinoPkg::floorY;
      vel <= '0;
    end else begin
      dinoY <= nextY;
      vel <= nextVel;
    end
  end

endmodule

//--- obstacleScroller.sv
`timescale 1ns/1ps

module obstacleScroller (
  input logic clk,
  input logic nRst,
  input logic tick,
  obstacleIf.scroller obs
);

  typedef enum logic {
    gap,
    moving
  } scrollStateT;

  scrollStateT state;
  logic [2:0] gapCnt; // empty frames seen so far
  dinoPkg::lfsrT lfsr;
  dinoPkg::lfsrT lfsrNext;
  dinoPkg::coordT nextX;
  dinoPkg::coordT oldRight;
  dinoPkg::coordT newRight;
  logic spawnNow;
  logic retireNow;
  logic crossNow; // right edge crosses the dinosaur this frame

  always_comb begin
    lfsrNext = {1'b0, lfsr[7:1]};
    if (lfsr[0]) begin
      lfsrNext = lfsrNext ^ dinoPkg::lfsrTaps;
    end
  end

  assign nextX = obs.x - dinoPkg::scrollStep;
  assign oldRight = obs.x + dinoPkg::obsW;
  assign newRight = nextX + dinoPkg::obsW;

  assign spawnNow = (state == gap) && (gapCnt == dinoPkg::gapFrames - 3'd1);
  assign retireNow = (state == moving) && (obs.x < dinoPkg::scrollStep);
  assign crossNow = (state == moving) && !retireNow
                    && (newRight <= dinoPkg::dinoX) && (oldRight > dinoPkg::dinoX);

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      state <= gap;
      gapCnt <= '0;
      lfsr <= dinoPkg::lfsrSeed;
      obs.active <= 1'b0;
      obs.passed <= 1'b0;
      obs.x <= '0;
      obs.height <= '0;
    end else begin
      obs.passed <= 1'b0; // pulse only
      if (tick) begin
        case (state)
          gap: begin
            if (spawnNow) begin
              gapCnt <= '0;
              obs.x <= dinoPkg::spawnX;
              obs.height <= dinoPkg::minObsH + {4'd0, lfsr[3:0]};
              lfsr <= lfsrNext;
              obs.active <= 1'b1;
              state <= moving;
            end else begin
              gapCnt <= gapCnt + 3'd1;
            end
          end
          moving: begin
            if (retireNow) begin // off the left edge
              obs.active <= 1'b0;
              state <= gap;
            end else begin
              obs.x <= nextX;
              obs.passed <= crossNow;
            end
          end
          default: state <= gap;
        endcase
      end
    end
  end

endmodule

//--- gameJudge.sv
`timescale 1ns/1ps

module gameJudge (
  input logic clk,
  input logic nRst,
  input logic tick,
  input dinoPkg::coordT dinoY,
  obstacleIf.judge obs,
  output dinoPkg::scoreT score,
  output logic gameOver
);

  logic tickD; // positions settled one cycle after tick
  logic overlap;
  logic collide;
  dinoPkg::coordT dinoRise; // height above the floor
  dinoPkg::coordT obsRight;

  assign dinoRise = dinoY - dinoPkg::floorY;
  assign obsRight = obs.x + dinoPkg::obsW;

  always_comb begin
    overlap = (obs.x < dinoPkg::dinoX + dinoPkg::dinoW) && (obsRight > dinoPkg::dinoX);
    collide = obs.active && overlap && (dinoRise < obs.height);
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      tickD <= 1'b0;
    end else begin
      tickD <= tick;
    end
  end

  always_ff @(posedge clk, negedge nRst) begin
    if (!nRst) begin
      score <= '0;
      gameOver <= 1'b0;
    end else if (tickD && !gameOver) begin
      if (collide) begin
        gameOver <= 1'b1; // sticky until reset
      end else if (obs.passed) begin
        score <= score + 1'b1;
      end
    end
  end

endmodule

//--- dinoGameTop.sv
`timescale 1ns/1ps

module dinoGameTop #(
  parameter int unsigned frameDiv = 1000000
) (
  input logic clk,
  input logic nRst,
  input logic button,
  output logic frameTick,
  output dinoPkg::coordT dinoY,
  output logic obstacleActive,
  output dinoPkg::coordT obstacleX,
  output dinoPkg::coordT obstacleHeight,
  output dinoPkg::scoreT score,
  output logic gameOver
);

  logic tick;

  obstacleIf obsBus ();

  frameTimer #(
    .frameDiv(frameDiv)
  ) timer0 (
    .clk(clk),
    .nRst(nRst),
    .gameOver(gameOver),
    .tick(tick)
  );

  dinoJump jump0 (
    .clk(clk),
    .nRst(nRst),
    .tick(tick),
    .button(button),
    .dinoY(dinoY)
  );

  obstacleScroller scroller0 (
    .clk(clk),
    .nRst(nRst),
    .tick(tick),
    .obs(obsBus.scroller)
  );

  gameJudge judge0 (
    .clk(clk),
    .nRst(nRst),
    .tick(tick),
    .dinoY(dinoY),
    .obs(obsBus.judge),
    .score(score),
    .gameOver(gameOver)
  );

  // renderer side
  assign frameTick = tick;
  assign obstacleActive = obsBus.active;
  assign obstacleX = obsBus.x;
  assign obstacleHeight = obsBus.height;

endmodule

//--- dinoGameTb.sv
`timescale 1ns/1ps

module dinoGameTb;

  localparam int frameDiv = 4;
  localparam int clkPeriod = 20;
  localparam string patternFile = "dinoGamePatterns.txt";

  logic clk;
  logic nRst;
  logic button;
  logic frameTick;
  dinoPkg::coordT dinoY;
  logic obstacleActive;
  dinoPkg::coordT obstacleX;
  dinoPkg::coordT obstacleHeight;
  dinoPkg::scoreT score;
  logic gameOver;

  // one entry per pattern line
  string testNames[$];
  int frameCounts[$];
  int buttonVals[$];
  int expDinoY[$];
  int expObsX[$];
  int expObsH[$];
  int expActive[$];
  int expScore[$];
  int expOver[$];

  integer seed;
  int testErrors;
  int passCount;
  int failCount;
  int totalFrames;
  longint watchdogNs;
  bit loaded;
  bit loadOk;

  dinoGameTop #(
    .frameDiv(frameDiv)
  ) dut0 (
    .clk(clk),
    .nRst(nRst),
    .button(button),
    .frameTick(frameTick),
    .dinoY(dinoY),
    .obstacleActive(obstacleActive),
    .obstacleX(obstacleX),
    .obstacleHeight(obstacleHeight),
    .score(score),
    .gameOver(gameOver)
  );

  always #(clkPeriod / 2) clk = ~clk;

  task automatic readPatterns(output bit ok);
    int fd;
    int n;
    string tok;
    string rest;
    int fr, bt, ey, ex, eh, ea, es, eg;
    ok = 1'b0;
    fd = $fopen(patternFile, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        n = $fscanf(fd, "%s", tok);
        if (n == 1) begin
          if (tok.substr(0, 0) == "#") begin
            n = $fgets(rest, fd); // column notes
          end else begin
            n = $fscanf(fd, "%d %d %d %d %d %d %d %d", fr, bt, ey, ex, eh, ea, es, eg);
            if (n != 8) begin
              $display("pattern line for %s has %0d of 8 numbers", tok, n);
              ok = 1'b0;
              break;
            end
            testNames.push_back(tok);
            frameCounts.push_back(fr);
            buttonVals.push_back(bt);
            expDinoY.push_back(ey);
            expObsX.push_back(ex);
            expObsH.push_back(eh);
            expActive.push_back(ea);
            expScore.push_back(es);
            expOver.push_back(eg);
          end
        end
      end
      $fclose(fd);
      if (testNames.size() == 0) begin
        ok = 1'b0;
      end
    end
  endtask

  // one frame, either a real tick or frameDiv clocks once play is frozen
  task automatic waitFrame();
    int idle;
    idle = 0;
    do begin
      @(negedge clk);
      idle++;
      assert (!(frameTick && gameOver)) else begin
        $display("frame tick arrived although the game is over");
        testErrors++;
      end
    end while (!frameTick && !(gameOver && idle >= frameDiv));
  endtask

  task automatic checkField(input string testName, input string field,
                            input int expVal, input int actVal);
    assert (actVal == expVal) else begin
      $display("CHECK FAILED %s %s expected %0d actual %0d", testName, field, expVal, actVal);
      testErrors++;
    end
  endtask

  task automatic runTest(input int idx);
    int jitter;
    testErrors = 0;
    if ((buttonVals[idx] != 0) != button) begin
      jitter = $random(seed) & 1; // a frame has one spare negedge before its tick
      repeat (jitter) @(negedge clk);
    end
    button = (buttonVals[idx] != 0);
    for (int f = 0; f < frameCounts[idx]; f++) begin
      waitFrame();
    end
    repeat (2) @(negedge clk); // judge outputs settle two cycles after the tick
    checkField(testNames[idx], "dinoY", expDinoY[idx], int'(dinoY));
    checkField(testNames[idx], "obstacleX", expObsX[idx], int'(obstacleX));
    checkField(testNames[idx], "obstacleHeight", expObsH[idx], int'(obstacleHeight));
    checkField(testNames[idx], "obstacleActive", expActive[idx], int'(obstacleActive));
    checkField(testNames[idx], "score", expScore[idx], int'(score));
    checkField(testNames[idx], "gameOver", expOver[idx], int'(gameOver));
    if (testErrors == 0) begin
      passCount++;
      $display("ok    %s after %0d frames", testNames[idx], frameCounts[idx]);
    end else begin
      failCount++;
      $display("FAIL  %s after %0d frames", testNames[idx], frameCounts[idx]);
    end
  endtask

  initial begin
    clk = 1'b0;
    nRst = 1'b0;
    button = 1'b0;
    seed = 32'h6471;
    testErrors = 0;
    passCount = 0;
    failCount = 0;
    totalFrames = 0;
    loaded = 1'b0;
    readPatterns(loadOk);
    if (!loadOk) begin
      $display("pattern file %s is missing or malformed", patternFile);
      $display("TESTBENCH FAILED");
    end else begin
      foreach (frameCounts[i]) begin
        totalFrames += frameCounts[i];
      end
      watchdogNs = longint'(totalFrames) * frameDiv * clkPeriod
                   + longint'(testNames.size() * 4 + 20) * clkPeriod;
      loaded = 1'b1;
      repeat (2) @(negedge clk);
      nRst = 1'b1;
      foreach (testNames[i]) begin
        runTest(i);
      end
      $display("%0d tests, %0d passed, %0d failed", testNames.size(), passCount, failCount);
      if (failCount == 0) begin
        $display("TESTBENCH PASSED");
      end else begin
        $display("TESTBENCH FAILED");
      end
    end
    $finish;
  end

  initial begin
    wait (loaded);
    #(watchdogNs);
    $display("watchdog expired after %0d ns, frame ticks stopped arriving", watchdogNs);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

//--- dinoGamePatterns.txt
# name frames button, then expected after the last frame:
# dinoY obstacleX obstacleHeight obstacleActive score gameOver
reset 1 0 151 0 0 0 0 0
jumpKick 1 1 161 0 0 0 0 0
rise1 1 0 169 0 0 0 0 0
rise2 1 0 175 0 0 0 0 0
rise3 1 0 179 0 0 0 0 0
apexSpawn 1 0 181 160 15 1 0 0
airPress 3 1 175 148 15 1 0 0
fall 2 1 161 140 15 1 0 0
land 1 1 151 136 15 1 0 0
scrollStep 1 0 151 132 15 1 0 0
scroll 9 0 151 96 15 1 0 0
scrollFar 13 0 151 44 15 1 0 0
clearJump 1 1 161 40 15 1 0 0
clearRise 3 0 179 28 15 1 0 0
clearApex 3 0 179 16 15 1 0 0
passed 1 0 175 12 15 1 1 0
cleared 3 0 151 0 15 1 1 0
retire 1 0 151 0 15 0 1 0
gap 5 0 151 0 15 0 1 0
spawn2 1 0 151 160 20 1 1 0
approach 32 0 151 32 20 1 1 0
collide 1 0 151 28 20 1 1 1
frozen 5 1 151 28 20 1 1 1

//--- tb.f
dinoPkg.sv
obstacleIf.sv
frameTimer.sv
dinoJump.sv
obstacleScroller.sv
gameJudge.sv
dinoGameTop.sv
dinoGameTb.sv

//--- Bender.yml
package:
  name: dino_game

sources:
  - dinoPkg.sv
  - obstacleIf.sv
  - frameTimer.sv
  - dinoJump.sv
  - obstacleScroller.sv
  - gameJudge.sv
  - dinoGameTop.sv
  - target: test
    files:
      - dinoGameTb.sv

# testbench top is dinoGameTb, design top is dinoGameTop
